//--- rvLsu_defines.svh
// LSU build parameters.
// Sizing of the on-chip data memory, shared by RTL and testbench.

`ifndef RVLSU_DEFINES_SVH
`define RVLSU_DEFINES_SVH

// Number of 64-bit memory words is 2**LSU_MEM_DEPTH_LOG2.
`define LSU_MEM_DEPTH_LOG2 8

// Word index taken from address bits above the byte offset.
`define LSU_INDEX_W `LSU_MEM_DEPTH_LOG2

`endif

//--- rvLsu_pkg.sv
// LSU shared definitions.
// Memory-op encodings and the lane views of one 64-bit memory word.

`default_nettype none

package rvLsu_pkg;

    // Bit 2 selects zero extension, bits 1:0 give the access size.
    localparam logic [2:0] OP_LW  = 3'b000;
    localparam logic [2:0] OP_LB  = 3'b001;
    localparam logic [2:0] OP_LH  = 3'b010;
    localparam logic [2:0] OP_LD  = 3'b011;
    localparam logic [2:0] OP_LWU = 3'b100;
    localparam logic [2:0] OP_LBU = 3'b101;
    localparam logic [2:0] OP_LHU = 3'b110;

    // One memory word seen at each access width.
    typedef union packed {
        logic [7:0][7:0]  bytes;  // Lane 0 is the lowest address.
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
        logic [63:0]      dword;
    } memWord_u;

endpackage

`default_nettype wire

//--- rvLsu_if.sv
// LSU internal interfaces.
// memReqIf runs from the aligner to the data memory, loadTagIf carries
// the per-request tag from the aligner to the load extractor.

`timescale 1ns/1ps
`default_nettype none
`include "rvLsu_defines.svh"

interface memReqIf;
    logic                    valid;  // Read enable.
    logic                    write;  // Already qualified by alignment.
    logic [`LSU_INDEX_W-1:0] index;
    logic [63:0]             wdata;
    logic [7:0]              wstrb;

    modport master (output valid, write, index, wdata, wstrb);
    modport slave  (input  valid, write, index, wdata, wstrb);
endinterface

interface loadTagIf;
    logic       valid;
    logic       isLoad;
    logic [2:0] op;
    logic [2:0] offset;      // Byte offset within the word.
    logic       misaligned;

    modport master (output valid, isLoad, op, offset, misaligned);
    modport slave  (input  valid, isLoad, op, offset, misaligned);
endinterface

`default_nettype wire

//--- accessAlign.sv
// Request decode and alignment.
// Checks the address against the access size, places store data into its
// byte lanes with a matching strobe and forwards the load tag.

`timescale 1ns/1ps
`default_nettype none
`include "rvLsu_defines.svh"

module accessAlign (
    input  logic        reqValid,
    input  logic        reqWrite,
    input  logic [2:0]  reqOp,
    input  logic [63:0] reqAddr,
    input  logic [63:0] reqWdata,
    memReqIf.master     memReq,
    loadTagIf.master    tag
);
    import rvLsu_pkg::*;

    logic [2:0] offset;
    logic       misaligned;
    memWord_u   storeWord;
    logic [7:0] storeStrb;

    assign offset = reqAddr[2:0];

    always_comb begin
        case (reqOp[1:0])
            OP_LB[1:0]: misaligned = 1'b0;
            OP_LH[1:0]: misaligned = offset[0];
            OP_LW[1:0]: misaligned = |offset[1:0];
            default:    misaligned = |offset;  // Double.
        endcase
    end

    // Unused lanes stay zero, only strobed bytes reach memory.
    always_comb begin
        storeWord = '0;
        storeStrb = '0;
        case (reqOp[1:0])
            OP_LB[1:0]: begin
                storeWord.bytes[offset] = reqWdata[7:0];
                storeStrb = 8'b0000_0001 << offset;
            end
            OP_LH[1:0]: begin
                storeWord.halves[offset[2:1]] = reqWdata[15:0];
                storeStrb = 8'b0000_0011 << offset;
            end
            OP_LW[1:0]: begin
                storeWord.words[offset[2]] = reqWdata[31:0];
                storeStrb = 8'b0000_1111 << offset;
            end
            default: begin
                storeWord.dword = reqWdata;
                storeStrb = 8'b1111_1111;
            end
        endcase
    end

    assign memReq.valid = reqValid;
    assign memReq.write = reqValid & reqWrite & ~misaligned;  // Misaligned stores dropped.
    assign memReq.index = reqAddr[`LSU_MEM_DEPTH_LOG2+2:3];   // Upper bits wrap.
    assign memReq.wdata = storeWord.dword;
    assign memReq.wstrb = storeStrb;

    assign tag.valid      = reqValid;
    assign tag.isLoad     = ~reqWrite;
    assign tag.op         = reqOp;
    assign tag.offset     = offset;
    assign tag.misaligned = misaligned;

endmodule

`default_nettype wire

//--- dataMem.sv
// Data memory.
// 64-bit words with per-byte write strobes and a registered read port.

`timescale 1ns/1ps
`default_nettype none
`include "rvLsu_defines.svh"

module dataMem (
    input  logic        clk,
    memReqIf.slave      memReq,
    output logic [63:0] readData
);
    localparam int memDepth = 1 << `LSU_MEM_DEPTH_LOG2;

    logic [63:0] mem [memDepth];

    // Read sees the contents from before a same-cycle write.
    always_ff @(posedge clk) begin
        if (memReq.valid) begin
            readData <= mem[memReq.index];
        end
        if (memReq.write) begin
            for (int i = 0; i < 8; i++) begin
                if (memReq.wstrb[i]) begin
                    mem[memReq.index][i*8 +: 8] <= memReq.wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- loadExtract.sv
// Load extraction.
// Delays the request tag to line up with the memory read, selects the
// addressed field, extends it to 64 bits and registers the response.

`timescale 1ns/1ps
`default_nettype none

module loadExtract (
    input  logic        clk,
    input  logic        arstN,
    loadTagIf.slave     tag,
    input  logic [63:0] readData,
    output logic        rspValid,
    output logic        rspLoad,
    output logic        rspMisaligned,
    output logic [63:0] rspData
);
    import rvLsu_pkg::*;

    logic        tagValid;
    logic        isLoad;
    logic [2:0]  op;
    logic [2:0]  offset;
    logic        misaligned;
    memWord_u    memWord;
    logic        signExt;
    logic [63:0] loadData;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tagValid <= 1'b0;
            rspValid <= 1'b0;
        end else begin
            tagValid <= tag.valid;
            rspValid <= tagValid;
        end
    end

    always_ff @(posedge clk) begin
        isLoad        <= tag.isLoad;  // Aligned with readData.
        op            <= tag.op;
        offset        <= tag.offset;
        misaligned    <= tag.misaligned;
        rspLoad       <= isLoad;
        rspMisaligned <= misaligned;
        rspData       <= loadData;
    end

    assign memWord = readData;
    assign signExt = ~op[2];  // Unsigned ops zero-extend.

    always_comb begin
        case (op[1:0])
            OP_LB[1:0]: loadData = {{56{signExt & memWord.bytes[offset][7]}},
                                    memWord.bytes[offset]};
            OP_LH[1:0]: loadData = {{48{signExt & memWord.halves[offset[2:1]][15]}},
                                    memWord.halves[offset[2:1]]};
            OP_LW[1:0]: loadData = {{32{signExt & memWord.words[offset[2]][31]}},
                                    memWord.words[offset[2]]};
            default:    loadData = memWord.dword;  // Unsigned bit has no effect.
        endcase
        if (!isLoad || misaligned) begin
            loadData = '0;
        end
    end

endmodule

`default_nettype wire

//--- rvLsu.sv
// RV64 load/store unit top level.
// Two-stage path: align and memory access, then load extraction.
// A response follows each request two cycles later.

`timescale 1ns/1ps
`default_nettype none

module rvLsu (
    input  logic        clk,
    input  logic        arstN,
    input  logic        reqValid,
    input  logic        reqWrite,
    input  logic [2:0]  reqOp,
    input  logic [63:0] reqAddr,
    input  logic [63:0] reqWdata,
    output logic        rspValid,
    output logic        rspLoad,
    output logic        rspMisaligned,
    output logic [63:0] rspData
);

    memReqIf     memReq ();
    loadTagIf    loadTag ();
    logic [63:0] readData;

    accessAlign align_i (
        .reqValid (reqValid),
        .reqWrite (reqWrite),
        .reqOp    (reqOp),
        .reqAddr  (reqAddr),
        .reqWdata (reqWdata),
        .memReq   (memReq.master),
        .tag      (loadTag.master)
    );

    dataMem mem_i (
        .clk      (clk),
        .memReq   (memReq.slave),
        .readData (readData)
    );

    loadExtract extract_i (
        .clk           (clk),
        .arstN         (arstN),
        .tag           (loadTag.slave),
        .readData      (readData),
        .rspValid      (rspValid),
        .rspLoad       (rspLoad),
        .rspMisaligned (rspMisaligned),
        .rspData       (rspData)
    );

endmodule

`default_nettype wire

//--- lsuChecker.sv
// LSU response checker.
// Keeps the expected responses in request order, compares each DUT
// response with them and keeps per-test and overall counts.

`timescale 1ns/1ps
`default_nettype none

module lsuChecker (
    input  logic        clk,
    input  logic        rspValid,
    input  logic        rspLoad,
    input  logic        rspMisaligned,
    input  logic [63:0] rspData,
    input  logic        expValid,
    input  logic        expLoad,
    input  logic        expMis,
    input  logic [63:0] expData,
    input  logic [3:0]  testNum,
    input  logic        testDone,
    input  logic        reportTotals,
    output int          pending,
    output int          errorCount
);
    localparam int rspLatency = 2;  // Cycles from request to response.

    logic        loadQ [$];
    logic        misQ [$];
    logic [63:0] dataQ [$];
    int          testQ [$];
    int          cycleQ [$];
    int          cycle = 0;
    int          pendingCount = 0;
    int          errorTotal = 0;
    int          checkTotal = 0;
    int          checks [16] = '{default: 0};
    int          errors [16] = '{default: 0};

    assign pending    = pendingCount;
    assign errorCount = errorTotal;

    // Sampled on the falling edge.
    always @(negedge clk) begin : compare
        logic        eLoad;
        logic        eMis;
        logic [63:0] eData;
        int          eTest;
        int          eCycle;
        logic        bad;
        cycle = cycle + 1;
        if (expValid) begin
            loadQ.push_back(expLoad);
            misQ.push_back(expMis);
            dataQ.push_back(expData);
            testQ.push_back(int'(testNum));
            cycleQ.push_back(cycle);
        end
        if (rspValid) begin
            if (dataQ.size() == 0) begin
                $display("unexpected response while no request is outstanding");
                errors[testNum] = errors[testNum] + 1;
                errorTotal = errorTotal + 1;
            end else begin
                eLoad  = loadQ.pop_front();
                eMis   = misQ.pop_front();
                eData  = dataQ.pop_front();
                eTest  = testQ.pop_front();
                eCycle = cycleQ.pop_front();
                bad    = 1'b0;
                if (rspData !== eData) begin
                    $display("error test %0d: rspData got %h expected %h", eTest, rspData, eData);
                    bad = 1'b1;
                end
                if (rspLoad !== eLoad) begin
                    $display("error test %0d: rspLoad got %h expected %h", eTest, rspLoad, eLoad);
                    bad = 1'b1;
                end
                if (rspMisaligned !== eMis) begin
                    $display("error test %0d: rspMisaligned got %h expected %h",
                             eTest, rspMisaligned, eMis);
                    bad = 1'b1;
                end
                if (cycle - eCycle != rspLatency) begin
                    $display("test %0d: response came %0d cycles after its request, not %0d",
                             eTest, cycle - eCycle, rspLatency);
                    bad = 1'b1;
                end
                checks[eTest] = checks[eTest] + 1;
                checkTotal = checkTotal + 1;
                if (bad) begin
                    errors[eTest] = errors[eTest] + 1;
                    errorTotal = errorTotal + 1;
                end
            end
        end
        pendingCount = dataQ.size();
        if (testDone) begin
            $display("test %0d done: %0d checks, %0d errors",
                     testNum, checks[testNum], errors[testNum]);
        end
        if (reportTotals) begin
            $display("all tests: %0d checks, %0d errors", checkTotal, errorTotal);
        end
    end

endmodule

`default_nettype wire

//--- lsuTb.sv
// LSU testbench.
// Drives directed and random requests into rvLsu, models the memory
// and passes the expected responses to the checker.

`timescale 1ns/1ps
`default_nettype none
`include "rvLsu_defines.svh"

module lsuTb;
    import rvLsu_pkg::*;

    localparam int memDepth   = 1 << `LSU_MEM_DEPTH_LOG2;
    localparam int test1Reqs  = 16;
    localparam int test2Reqs  = 29;
    localparam int test3Reqs  = 62;
    localparam int test4Reqs  = 36;
    localparam int test5Reqs  = 316;
    localparam int totalReqs  = test1Reqs + test2Reqs + test3Reqs + test4Reqs + test5Reqs;
    localparam int cycleLimit = 2 * totalReqs + 50;

    logic        clk;
    logic        arstN;
    logic        reqValid;
    logic        reqWrite;
    logic [2:0]  reqOp;
    logic [63:0] reqAddr;
    logic [63:0] reqWdata;
    logic        rspValid;
    logic        rspLoad;
    logic        rspMisaligned;
    logic [63:0] rspData;
    logic        expValid;
    logic        expLoad;
    logic        expMis;
    logic [63:0] expData;
    logic [3:0]  testNum;
    logic        testDone;
    logic        reportTotals;
    int          pending;
    int          errorCount;
    int          cycleCount = 0;
    integer      seed;
    logic [63:0] refMem [memDepth];

    rvLsu dut_i (
        .clk           (clk),
        .arstN         (arstN),
        .reqValid      (reqValid),
        .reqWrite      (reqWrite),
        .reqOp         (reqOp),
        .reqAddr       (reqAddr),
        .reqWdata      (reqWdata),
        .rspValid      (rspValid),
        .rspLoad       (rspLoad),
        .rspMisaligned (rspMisaligned),
        .rspData       (rspData)
    );

    lsuChecker chk_i (
        .clk           (clk),
        .rspValid      (rspValid),
        .rspLoad       (rspLoad),
        .rspMisaligned (rspMisaligned),
        .rspData       (rspData),
        .expValid      (expValid),
        .expLoad       (expLoad),
        .expMis        (expMis),
        .expData       (expData),
        .testNum       (testNum),
        .testDone      (testDone),
        .reportTotals  (reportTotals),
        .pending       (pending),
        .errorCount    (errorCount)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic int sizeBytes(input logic [2:0] op);
        case (op[1:0])
            2'b00:   return 4;
            2'b01:   return 1;
            2'b10:   return 2;
            default: return 8;
        endcase
    endfunction

    function automatic logic isMisaligned(input logic [2:0] op, input logic [2:0] offset);
        return (int'(offset) % sizeBytes(op)) != 0;
    endfunction

    // Expected load data from a memory word.
    function automatic logic [63:0] refLoad(input logic [63:0] word, input logic [2:0] op,
                                            input logic [2:0] offset);
        int          nBytes;
        logic [63:0] field;
        logic [63:0] mask;
        nBytes = sizeBytes(op);
        field  = word >> (8 * offset);
        if (nBytes == 8) begin
            return field;  // Double ignores the unsigned bit.
        end
        mask  = (64'd1 << (8 * nBytes)) - 64'd1;
        field = field & mask;
        if (!op[2] && field[8 * nBytes - 1]) begin
            field = field | ~mask;
        end
        return field;
    endfunction

    function automatic void writeRef(input logic [`LSU_INDEX_W-1:0] idx, input logic [2:0] op,
                                     input logic [2:0] offset, input logic [63:0] wdata);
        int n;
        n = sizeBytes(op);
        for (int b = 0; b < n; b++) begin
            refMem[idx][8 * (int'(offset) + b) +: 8] = wdata[8 * b +: 8];
        end
    endfunction

    function automatic logic [63:0] makeAddr(input logic [63:0] upper, input int idx,
                                             input logic [2:0] offset);
        return (upper << (`LSU_INDEX_W + 3)) | (64'(idx) << 3) | 64'(offset);
    endfunction

    function automatic logic [63:0] fillWord(input int idx);
        return 64'h9E37_79B9_7F4A_7C15 ^ (64'(idx) * 64'h0101_0101_0101_0101);
    endfunction

    task automatic sendRequest(input logic write, input logic [2:0] op,
                               input logic [63:0] addr, input logic [63:0] wdata);
        logic [`LSU_INDEX_W-1:0] idx;
        logic [2:0]              offset;
        logic                    mis;
        idx    = addr[`LSU_MEM_DEPTH_LOG2+2:3];
        offset = addr[2:0];
        mis    = isMisaligned(op, offset);
        @(posedge clk);
        #1;
        reqValid = 1'b1;
        reqWrite = write;
        reqOp    = op;
        reqAddr  = addr;
        reqWdata = wdata;
        expValid = 1'b1;
        expLoad  = ~write;
        expMis   = mis;
        expData  = (!write && !mis) ? refLoad(refMem[idx], op, offset) : 64'd0;
        if (write && !mis) begin
            writeRef(idx, op, offset, wdata);
        end
    endtask

    // Idle, wait for the checker to drain, then mark the test done.
    task automatic finishTest();
        @(posedge clk);
        #1;
        reqValid = 1'b0;
        expValid = 1'b0;
        while (pending != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
        testDone = 1'b1;
        @(posedge clk);
        #1;
        testDone = 1'b0;
    endtask

    task automatic runDoubleTest();
        for (int i = 0; i < 8; i++) begin
            sendRequest(1'b1, OP_LD, makeAddr(64'd0, i * 37 + 3, 3'd0),
                        64'h0F1E_2D3C_4B5A_6978 * 64'(i + 1));
        end
        for (int i = 0; i < 8; i++) begin
            sendRequest(1'b0, OP_LD, makeAddr(64'd0, i * 37 + 3, 3'd0), 64'd0);
        end
        finishTest();
    endtask

    task automatic runLaneStoreTest();
        logic [2:0] storeOps [3];
        logic [7:0] k;
        storeOps = '{OP_LB, OP_LH, OP_LW};
        k = 8'h80;
        sendRequest(1'b1, OP_LD, makeAddr(64'd0, 20, 3'd0), 64'h0123_4567_89AB_CDEF);
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 8; off += sizeBytes(storeOps[s])) begin
                sendRequest(1'b1, storeOps[s], makeAddr(64'd0, 20, 3'(off)), {8{k}});
                sendRequest(1'b0, OP_LD, makeAddr(64'd0, 20, 3'd0), 64'd0);
                k = k + 8'd1;
            end
        end
        finishTest();
    endtask

    // All eight op codes, the double with the unsigned bit included.
    task automatic runLoadExtendTest();
        logic [63:0] patterns [2];
        patterns = '{64'h8000_7FFF_FF7F_0180, 64'h7FFF_8000_0080_FE7F};
        for (int p = 0; p < 2; p++) begin
            sendRequest(1'b1, OP_LD, makeAddr(64'd0, 40, 3'd0), patterns[p]);
            for (int op = 0; op < 8; op++) begin
                for (int off = 0; off < 8; off++) begin
                    if (!isMisaligned(3'(op), 3'(off))) begin
                        sendRequest(1'b0, 3'(op), makeAddr(64'd0, 40, 3'(off)), 64'd0);
                    end
                end
            end
        end
        finishTest();
    endtask

    task automatic runMisalignTest();
        logic [2:0] misOps [3];
        misOps = '{OP_LH, OP_LW, OP_LD};
        sendRequest(1'b1, OP_LD, makeAddr(64'd0, 60, 3'd0), 64'hFEDC_BA98_7654_3210);
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 8; off++) begin
                if (isMisaligned(misOps[s], 3'(off))) begin
                    sendRequest(1'b1, misOps[s], makeAddr(64'd0, 60, 3'(off)), '1);
                    sendRequest(1'b0, misOps[s], makeAddr(64'd0, 60, 3'(off)), 64'd0);
                end
            end
        end
        sendRequest(1'b0, OP_LD, makeAddr(64'd0, 60, 3'd0), 64'd0);  // Memory unchanged.
        finishTest();
    endtask

    task automatic runRandomTest();
        logic        write;
        logic [2:0]  op;
        logic [63:0] upper;
        logic [63:0] wdata;
        int          idx;
        for (int i = 0; i < 16; i++) begin
            sendRequest(1'b1, OP_LD, makeAddr(64'd0, i, 3'd0), fillWord(i));
        end
        for (int n = 0; n < 300; n++) begin
            write = 1'($random(seed));
            op    = 3'({$random(seed)} % 7);
            idx   = int'({$random(seed)} % 16);
            upper = {$random(seed), $random(seed)};  // Exercises address wrap.
            wdata = {$random(seed), $random(seed)};
            sendRequest(write, op, makeAddr(upper, idx, 3'($random(seed))), wdata);
        end
        finishTest();
    endtask

    initial begin
        seed         = 81061;
        arstN        = 1'b0;
        reqValid     = 1'b0;
        reqWrite     = 1'b0;
        reqOp        = 3'd0;
        reqAddr      = 64'd0;
        reqWdata     = 64'd0;
        expValid     = 1'b0;
        expLoad      = 1'b0;
        expMis       = 1'b0;
        expData      = 64'd0;
        testNum      = 4'd0;
        testDone     = 1'b0;
        reportTotals = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;
        testNum = 4'd1;
        runDoubleTest();
        testNum = 4'd2;
        runLaneStoreTest();
        testNum = 4'd3;
        runLoadExtendTest();
        testNum = 4'd4;
        runMisalignTest();
        testNum = 4'd5;
        runRandomTest();
        reportTotals = 1'b1;
        @(posedge clk);
        #1;
        reportTotals = 1'b0;
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rvLsu.f
+incdir+.
rvLsu_pkg.sv
rvLsu_if.sv
accessAlign.sv
dataMem.sv
loadExtract.sv
rvLsu.sv
lsuChecker.sv
lsuTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the LSU testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f rvLsu.f --top-module lsuTb -o lsuSim

simOut=$(./obj_dir/lsuSim)
echo "$simOut"

if grep -qxF '*** PASSED ***' <<< "$simOut"; then
    exit 0
fi
exit 1
